//--- conv_out_settings.svh
`ifndef CONV_OUT_SETTINGS_SVH
`define CONV_OUT_SETTINGS_SVH

////////////////////////////////////////
// array shape
////////////////////////////////////////
`define SA_ROW_NUM          4
`define SA_COLUMN_NUM       3
`define FIFO_NUM            (`SA_ROW_NUM * `SA_COLUMN_NUM)
`define ARRAY_NO_WIDTH      4

// PE columns per core
`define COLUMN_NUM          4

////////////////////////////////////////
// data widths and depths
////////////////////////////////////////
`define PIXEL_WIDTH         8
`define OUT_DATA_WIDTH      (`PIXEL_WIDTH * 2 * `COLUMN_NUM)
`define ROW_WIDTH           (2 * `OUT_DATA_WIDTH)
`define IDX_WIDTH           16
`define FIFO_DEPTH          16

// channels per output group, 8x8 and 1x8
`define CHANNELS_MODE0      16
`define CHANNELS_MODE0_LOG2 4
`define CHANNELS_MODE1      32
`define CHANNELS_MODE1_LOG2 5

// output buffer layout
`define BUF_F_STRIDE        128
`define BUF_DEPTH           512
`define BUF_ADDR_WIDTH      9

`endif

//--- conv_out_pkg.sv
`default_nettype none

`include "conv_out_settings.svh"

package conv_out_pkg;

  // one full FIFO row, both halves
  typedef logic [`ROW_WIDTH-1:0] row_word_t;

  // one output word, a half row
  typedef logic [`OUT_DATA_WIDTH-1:0] out_word_t;

  // tensor index or extent
  typedef logic [`IDX_WIDTH-1:0] idx_t;

  // one bit per row FIFO
  typedef logic [`FIFO_NUM-1:0] fifo_sel_t;

  typedef logic [`BUF_ADDR_WIDTH-1:0] buf_addr_t;

  typedef enum logic [1:0] {
    BUF_IDLE,
    BUF_FILLING,
    BUF_DONE
  } buf_state_e;

endpackage

`default_nettype wire

//--- conv_row_fifo.sv
`timescale 1ns/1ps
`default_nettype none

`include "conv_out_settings.svh"

module conv_row_fifo import conv_out_pkg::*; (
  input  wire        clk,
  input  wire        reset,
  input  wire        wr_en,
  input  row_word_t  wr_data,
  input  wire        rd_en,
  output row_word_t  rd_data,
  output logic       empty,
  output logic       full
);

  localparam int PTR_W = $clog2(`FIFO_DEPTH);
  localparam logic [PTR_W:0] FULL_COUNT = `FIFO_DEPTH;

  row_word_t        mem [`FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W:0]   count;
  logic             do_wr;
  logic             do_rd;

  assign empty = (count == '0);
  assign full  = (count == FULL_COUNT);

  // overflow and underflow are simply dropped
  assign do_wr = wr_en && !full;
  assign do_rd = rd_en && !empty;

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_wr) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_rd) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      if (do_wr && !do_rd) begin
        count <= count + 1'b1;
      end else if (do_rd && !do_wr) begin
        count <= count - 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (do_wr) begin
      mem[wr_ptr] <= wr_data;
    end
    // head word, held until the next read
    if (do_rd) begin
      rd_data <= mem[rd_ptr];
    end
  end

endmodule

`default_nettype wire

//--- conv_fifo_bank.sv
`timescale 1ns/1ps
`default_nettype none

`include "conv_out_settings.svh"

module conv_fifo_bank import conv_out_pkg::*; (
  input  wire        clk,
  input  wire        reset,
  input  fifo_sel_t  pe_wr_en,
  input  row_word_t  pe_wr_data,
  input  fifo_sel_t  fifo_rds,
  output row_word_t  fifo_data,
  output fifo_sel_t  fifo_empty
);

  localparam int SEL_W = $clog2(`FIFO_NUM);

  row_word_t        rd_data_arr [`FIFO_NUM];
  logic [SEL_W-1:0] last_sel;
  logic [SEL_W-1:0] next_sel;

  ////////////////////////////////////////
  // row FIFOs, one per core
  ////////////////////////////////////////
  genvar i;
  generate
    for (i = 0; i < `FIFO_NUM; i++) begin : g_fifo
      conv_row_fifo u_row_fifo (
        .clk     (clk),
        .reset   (reset),
        .wr_en   (pe_wr_en[i]),
        .wr_data (pe_wr_data),
        .rd_en   (fifo_rds[i]),
        .rd_data (rd_data_arr[i]),
        .empty   (fifo_empty[i]),
        .full    ()
      );
    end
  endgenerate

  ////////////////////////////////////////
  // read select
  ////////////////////////////////////////

  // strobes are one-hot, keep last pick when idle
  always_comb begin
    next_sel = last_sel;
    for (int k = 0; k < `FIFO_NUM; k++) begin
      if (fifo_rds[k]) begin
        next_sel = SEL_W'(k);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      last_sel <= '0;
    end else begin
      last_sel <= next_sel;
    end
  end

  // mode 1 high half reuses this held word
  assign fifo_data = rd_data_arr[last_sel];

endmodule

`default_nettype wire

//--- conv_fifo_out_controller.sv
`timescale 1ns/1ps
`default_nettype none

`include "conv_out_settings.svh"

module conv_fifo_out_controller import conv_out_pkg::*; (
  input  wire                        clk,
  input  wire                        reset,
  input  wire                        conv_fifo_out_start,
  input  wire                        ddr_en,
  input  wire                        mode,
  input  idx_t                       cur_ox_start,
  input  idx_t                       cur_oy_start,
  input  idx_t                       cur_of_start,
  input  idx_t                       cur_poy,
  input  idx_t                       cur_pof,
  input  row_word_t                  fifo_data,
  output fifo_sel_t                  fifo_rds,
  output logic [`ARRAY_NO_WIDTH-1:0] fifo_column_no,
  output logic [`ARRAY_NO_WIDTH-1:0] fifo_row_no,
  output logic                       valid_out,
  output idx_t                       out_y_idx,
  output idx_t                       out_x_idx,
  output idx_t                       out_f_idx,
  output out_word_t                  conv_out_data,
  output logic                       conv_fifo_out_tile_add_end
);

  logic      active;
  idx_t      channel_cnt;
  idx_t      of_cnt;
  idx_t      oy_cnt;
  logic      last_channel_odd;
  idx_t      channel_num;
  idx_t      log_channel_num;
  idx_t      of_base;
  idx_t      f_pos;
  idx_t      row_no;
  idx_t      col_no;
  idx_t      fifo_idx;
  logic      step;
  logic      channel_end;
  logic      of_end;
  logic      tile_end;
  logic      rd_strobe;
  out_word_t data_low;
  out_word_t data_high;
  out_word_t data_sel;

  assign channel_num     = mode ? idx_t'(`CHANNELS_MODE1) : idx_t'(`CHANNELS_MODE0);
  assign log_channel_num = mode ? idx_t'(`CHANNELS_MODE1_LOG2) : idx_t'(`CHANNELS_MODE0_LOG2);

  ////////////////////////////////////////
  // loop control
  ////////////////////////////////////////
  assign of_base  = of_cnt - 16'd1;
  assign f_pos    = of_base + channel_cnt;

  // a step only happens with ddr_en high
  assign step        = active && ddr_en;
  assign channel_end = step && ((f_pos == cur_pof) || (channel_cnt == channel_num));
  assign of_end      = channel_end && (f_pos == cur_pof);
  assign tile_end    = of_end && (oy_cnt == cur_poy);

  always_ff @(posedge clk) begin
    if (reset) begin
      active <= 1'b0;
    end else if (conv_fifo_out_start) begin
      active <= 1'b1;
    end else if (tile_end) begin
      active <= 1'b0;
    end
  end

  // channel, innermost
  always_ff @(posedge clk) begin
    if (reset) begin
      channel_cnt <= 16'd1;
    end else if (step) begin
      channel_cnt <= channel_end ? 16'd1 : channel_cnt + 16'd1;
    end
  end

  // output feature group
  always_ff @(posedge clk) begin
    if (reset) begin
      of_cnt <= 16'd1;
    end else if (channel_end) begin
      of_cnt <= of_end ? 16'd1 : of_cnt + channel_num;
    end
  end

  // output row, outermost
  always_ff @(posedge clk) begin
    if (reset) begin
      oy_cnt <= 16'd1;
    end else if (of_end) begin
      oy_cnt <= tile_end ? 16'd1 : oy_cnt + 16'd1;
    end
  end

  // parity of the channel behind the current output
  always_ff @(posedge clk) begin
    if (reset) begin
      last_channel_odd <= 1'b0;
    end else if (step) begin
      last_channel_odd <= channel_cnt[0];
    end
  end

  ////////////////////////////////////////
  // FIFO read strobes
  ////////////////////////////////////////
  assign row_no    = of_base >> log_channel_num;
  assign col_no    = oy_cnt - 16'd1;
  assign fifo_idx  = idx_t'(col_no * `SA_ROW_NUM) + row_no;

  // mode 1 reads on odd channels only
  assign rd_strobe = step && (mode ? channel_cnt[0] : 1'b1);

  genvar i;
  generate
    for (i = 0; i < `FIFO_NUM; i++) begin : g_rds
      assign fifo_rds[i] = rd_strobe && (fifo_idx == idx_t'(i));
    end
  endgenerate

  ////////////////////////////////////////
  // registered index stage
  ////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (reset || conv_fifo_out_tile_add_end) begin
      valid_out                  <= 1'b0;
      conv_fifo_out_tile_add_end <= 1'b0;
      out_y_idx                  <= '0;
      out_x_idx                  <= '0;
      out_f_idx                  <= '0;
      fifo_column_no             <= '0;
      fifo_row_no                <= '0;
    end else begin
      valid_out                  <= step;
      conv_fifo_out_tile_add_end <= tile_end;
      if (step) begin
        out_y_idx      <= cur_oy_start - 16'd1 + oy_cnt;
        out_x_idx      <= cur_ox_start;
        out_f_idx      <= cur_of_start - 16'd1 + f_pos;
        fifo_column_no <= col_no[`ARRAY_NO_WIDTH-1:0];
        fifo_row_no    <= row_no[`ARRAY_NO_WIDTH-1:0];
      end
    end
  end

  // odd channel took low half, even the high half
  assign data_low      = fifo_data[`OUT_DATA_WIDTH-1:0];
  assign data_high     = fifo_data[`ROW_WIDTH-1:`OUT_DATA_WIDTH];
  assign data_sel      = (mode && !last_channel_odd) ? data_high : data_low;
  assign conv_out_data = valid_out ? data_sel : '0;

endmodule

`default_nettype wire

//--- conv_out_buffer.sv
`timescale 1ns/1ps
`default_nettype none

`include "conv_out_settings.svh"

module conv_out_buffer import conv_out_pkg::*; (
  input  wire        clk,
  input  wire        reset,
  input  wire        conv_fifo_out_start,
  input  wire        valid_out,
  input  idx_t       out_y_idx,
  input  idx_t       out_f_idx,
  input  out_word_t  conv_out_data,
  input  wire        conv_fifo_out_tile_add_end,
  input  buf_addr_t  buf_rd_addr,
  output out_word_t  buf_rd_data,
  output logic       tile_done,
  output idx_t       words_written
);

  out_word_t   mem [`BUF_DEPTH];
  buf_state_e  state;
  logic [31:0] lin_addr;
  buf_addr_t   wr_addr;

  ////////////////////////////////////////
  // index to address
  ////////////////////////////////////////

  // fixed stride per output row, wraps at depth
  assign lin_addr = (32'(out_y_idx) * `BUF_F_STRIDE + 32'(out_f_idx)) % `BUF_DEPTH;
  assign wr_addr  = lin_addr[`BUF_ADDR_WIDTH-1:0];

  always_ff @(posedge clk) begin
    if (valid_out) begin
      mem[wr_addr] <= conv_out_data;
    end
    buf_rd_data <= mem[buf_rd_addr];
  end

  always_ff @(posedge clk) begin
    if (reset || conv_fifo_out_start) begin
      words_written <= '0;
    end else if (valid_out) begin
      words_written <= words_written + 16'd1;
    end
  end

  ////////////////////////////////////////
  // tile state
  ////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (reset) begin
      state <= BUF_IDLE;
    end else begin
      case (state)
        BUF_IDLE: begin
          if (conv_fifo_out_start) begin
            state <= BUF_FILLING;
          end
        end
        BUF_FILLING: begin
          if (conv_fifo_out_tile_add_end) begin
            state <= BUF_DONE;
          end
        end
        BUF_DONE: begin
          // next tile
          if (conv_fifo_out_start) begin
            state <= BUF_FILLING;
          end
        end
        default: begin
          state <= BUF_IDLE;
        end
      endcase
    end
  end

  assign tile_done = (state == BUF_DONE);

endmodule

`default_nettype wire

//--- conv_out_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "conv_out_settings.svh"

module conv_out_top import conv_out_pkg::*; (
  input  wire                        clk,
  input  wire                        reset,
  input  fifo_sel_t                  pe_wr_en,
  input  row_word_t                  pe_wr_data,
  input  wire                        conv_fifo_out_start,
  input  wire                        ddr_en,
  input  wire                        mode,
  input  idx_t                       cur_ox_start,
  input  idx_t                       cur_oy_start,
  input  idx_t                       cur_of_start,
  input  idx_t                       cur_poy,
  input  idx_t                       cur_pof,
  input  buf_addr_t                  buf_rd_addr,
  output out_word_t                  buf_rd_data,
  output logic                       conv_fifo_out_tile_add_end,
  output logic                       tile_done,
  output idx_t                       words_written,
  output logic                       valid_out,
  output idx_t                       out_y_idx,
  output idx_t                       out_x_idx,
  output idx_t                       out_f_idx,
  output out_word_t                  conv_out_data,
  output logic [`ARRAY_NO_WIDTH-1:0] fifo_row_no,
  output logic [`ARRAY_NO_WIDTH-1:0] fifo_column_no,
  output fifo_sel_t                  fifo_empty
);

  fifo_sel_t fifo_rds;
  row_word_t fifo_data;

  conv_fifo_bank u_conv_fifo_bank (
    .clk        (clk),
    .reset      (reset),
    .pe_wr_en   (pe_wr_en),
    .pe_wr_data (pe_wr_data),
    .fifo_rds   (fifo_rds),
    .fifo_data  (fifo_data),
    .fifo_empty (fifo_empty)
  );

  conv_fifo_out_controller u_conv_fifo_out_controller (
    .clk                        (clk),
    .reset                      (reset),
    .conv_fifo_out_start        (conv_fifo_out_start),
    .ddr_en                     (ddr_en),
    .mode                       (mode),
    .cur_ox_start               (cur_ox_start),
    .cur_oy_start               (cur_oy_start),
    .cur_of_start               (cur_of_start),
    .cur_poy                    (cur_poy),
    .cur_pof                    (cur_pof),
    .fifo_data                  (fifo_data),
    .fifo_rds                   (fifo_rds),
    .fifo_column_no             (fifo_column_no),
    .fifo_row_no                (fifo_row_no),
    .valid_out                  (valid_out),
    .out_y_idx                  (out_y_idx),
    .out_x_idx                  (out_x_idx),
    .out_f_idx                  (out_f_idx),
    .conv_out_data              (conv_out_data),
    .conv_fifo_out_tile_add_end (conv_fifo_out_tile_add_end)
  );

  conv_out_buffer u_conv_out_buffer (
    .clk                        (clk),
    .reset                      (reset),
    .conv_fifo_out_start        (conv_fifo_out_start),
    .valid_out                  (valid_out),
    .out_y_idx                  (out_y_idx),
    .out_f_idx                  (out_f_idx),
    .conv_out_data              (conv_out_data),
    .conv_fifo_out_tile_add_end (conv_fifo_out_tile_add_end),
    .buf_rd_addr                (buf_rd_addr),
    .buf_rd_data                (buf_rd_data),
    .tile_done                  (tile_done),
    .words_written              (words_written)
  );

endmodule

`default_nettype wire

//--- tb_conv_out.sv
`timescale 1ns/1ps
`default_nettype none

`include "conv_out_settings.svh"

module tb_conv_out import conv_out_pkg::*; ();

  localparam int CLK_PERIOD   = 4;
  localparam int RESET_CYCLES = 8;
  localparam int TILE_LIMIT   = 400;
  // 4 tiles of up to 200 steps each, times four for preload and reads
  localparam int WATCHDOG_NS  = 4 * 200 * CLK_PERIOD * 4;
  localparam int OY_START     = 2;
  localparam int OF_START     = 3;
  localparam int OX_START     = 5;

  logic      clk = 1'b0;
  logic      reset;
  fifo_sel_t pe_wr_en;
  row_word_t pe_wr_data;
  logic      conv_fifo_out_start;
  logic      ddr_en;
  logic      mode;
  idx_t      cur_ox_start;
  idx_t      cur_oy_start;
  idx_t      cur_of_start;
  idx_t      cur_poy;
  idx_t      cur_pof;
  buf_addr_t buf_rd_addr;
  out_word_t buf_rd_data;
  logic      conv_fifo_out_tile_add_end;
  logic      tile_done;
  idx_t      words_written;
  logic      valid_out;
  idx_t      out_y_idx;
  idx_t      out_x_idx;
  idx_t      out_f_idx;
  out_word_t conv_out_data;
  logic [`ARRAY_NO_WIDTH-1:0] fifo_row_no;
  logic [`ARRAY_NO_WIDTH-1:0] fifo_column_no;
  fifo_sel_t fifo_empty;

  // reference model, one entry per predicted output
  idx_t        exp_y [$];
  idx_t        exp_x [$];
  idx_t        exp_f [$];
  int          exp_fifo [$];
  out_word_t   exp_data [$];
  row_word_t   saved_words [$];
  fifo_sel_t   filled_mask;
  logic [31:0] lfsr_state;

  int   main_errs = 0;
  int   mon_errs = 0;
  int   end_errs = 0;
  int   clear_errs = 0;
  int   tests_passed = 0;
  int   tests_failed = 0;
  // monitor state
  logic run_q = 1'b0;
  logic ddr_q = 1'b0;
  logic start_q = 1'b0;
  logic step_prev;
  int   steps = 0;
  int   mon_count = 0;

  always #(CLK_PERIOD / 2) clk = ~clk;

  conv_out_top u_conv_out_top (
    .clk                        (clk),
    .reset                      (reset),
    .pe_wr_en                   (pe_wr_en),
    .pe_wr_data                 (pe_wr_data),
    .conv_fifo_out_start        (conv_fifo_out_start),
    .ddr_en                     (ddr_en),
    .mode                       (mode),
    .cur_ox_start               (cur_ox_start),
    .cur_oy_start               (cur_oy_start),
    .cur_of_start               (cur_of_start),
    .cur_poy                    (cur_poy),
    .cur_pof                    (cur_pof),
    .buf_rd_addr                (buf_rd_addr),
    .buf_rd_data                (buf_rd_data),
    .conv_fifo_out_tile_add_end (conv_fifo_out_tile_add_end),
    .tile_done                  (tile_done),
    .words_written              (words_written),
    .valid_out                  (valid_out),
    .out_y_idx                  (out_y_idx),
    .out_x_idx                  (out_x_idx),
    .out_f_idx                  (out_f_idx),
    .conv_out_data              (conv_out_data),
    .fifo_row_no                (fifo_row_no),
    .fifo_column_no             (fifo_column_no),
    .fifo_empty                 (fifo_empty)
  );

  ////////////////////////////////////////
  // helpers
  ////////////////////////////////////////

  // Galois form of x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  task automatic draw_bits(input int n, output row_word_t val);
    val = '0;
    for (int i = 0; i < n; i++) begin
      val        = {val[`ROW_WIDTH-2:0], lfsr_state[0]};
      lfsr_state = lfsr_next(lfsr_state);
    end
  endtask

  function automatic int total_errs();
    return main_errs + mon_errs + end_errs + clear_errs;
  endfunction

  task automatic push_fifo(input int idx, input row_word_t word);
    @(posedge clk);
    pe_wr_en   <= fifo_sel_t'(1) << idx;
    pe_wr_data <= word;
  endtask

  // walk channel, of and oy loops, preload FIFOs as words get read
  task automatic build_tile(input logic m, input int poy, input int pof, input logic reuse);
    int        chn;
    int        of;
    int        ch;
    int        fpos;
    int        fidx;
    int        widx;
    logic      group_done;
    logic      row_done;
    row_word_t word;
    exp_y.delete();
    exp_x.delete();
    exp_f.delete();
    exp_fifo.delete();
    exp_data.delete();
    if (!reuse) begin
      saved_words.delete();
    end
    filled_mask = '0;
    chn  = m ? `CHANNELS_MODE1 : `CHANNELS_MODE0;
    widx = 0;
    word = '0;
    for (int oy = 1; oy <= poy; oy++) begin
      of       = 1;
      row_done = 1'b0;
      while (!row_done) begin
        ch         = 1;
        group_done = 1'b0;
        while (!group_done) begin
          fpos = of - 1 + ch;
          fidx = (oy - 1) * `SA_ROW_NUM + (of - 1) / chn;
          // mode 1 takes a new word on odd channels only
          if (!m || (ch % 2 == 1)) begin
            if (reuse) begin
              word = saved_words[widx];
              widx++;
            end else begin
              draw_bits(`ROW_WIDTH, word);
              saved_words.push_back(word);
            end
            push_fifo(fidx, word);
            filled_mask[fidx] = 1'b1;
          end
          exp_y.push_back(idx_t'(OY_START - 1 + oy));
          exp_x.push_back(idx_t'(OX_START));
          exp_f.push_back(idx_t'(OF_START - 1 + fpos));
          exp_fifo.push_back(fidx);
          exp_data.push_back((m && (ch % 2 == 0)) ? word[`ROW_WIDTH-1:`OUT_DATA_WIDTH]
                                                  : word[`OUT_DATA_WIDTH-1:0]);
          if (fpos == pof) begin
            group_done = 1'b1;
            row_done   = 1'b1;
          end else if (ch == chn) begin
            group_done = 1'b1;
            of         = of + chn;
          end else begin
            ch++;
          end
        end
      end
    end
    @(posedge clk);
    pe_wr_en <= '0;
  endtask

  task automatic run_tile(input logic m, input int poy, input int pof,
                          input logic reuse, input logic gaps);
    int        cycles;
    logic      seen_end;
    row_word_t bits;
    @(posedge clk);
    mode         <= m;
    cur_poy      <= idx_t'(poy);
    cur_pof      <= idx_t'(pof);
    cur_oy_start <= idx_t'(OY_START);
    cur_of_start <= idx_t'(OF_START);
    cur_ox_start <= idx_t'(OX_START);
    build_tile(m, poy, pof, reuse);
    @(posedge clk);
    assert (fifo_empty == ~filled_mask) else begin
      main_errs++;
      $display("error at %0t: fifo_empty %b before start, expected %b", $time, fifo_empty,
               ~filled_mask);
    end
    conv_fifo_out_start <= 1'b1;
    @(posedge clk);
    conv_fifo_out_start <= 1'b0;
    cycles   = 0;
    seen_end = 1'b0;
    while (!seen_end && cycles < TILE_LIMIT) begin
      // ddr_en high about three cycles in four
      if (gaps) begin
        draw_bits(2, bits);
        ddr_en <= bits[0] | bits[1];
      end
      @(posedge clk);
      seen_end = conv_fifo_out_tile_add_end;
      cycles++;
    end
    ddr_en <= 1'b1;
    if (!seen_end) begin
      main_errs++;
      $display("tile end pulse did not arrive within %0d cycles", TILE_LIMIT);
    end
    @(posedge clk);
    assert (mon_count == exp_y.size()) else begin
      main_errs++;
      $display("error at %0t: %0d valid outputs, %0d predicted", $time, mon_count,
               exp_y.size());
    end
    // every preloaded word has been read
    assert (fifo_empty == '1) else begin
      main_errs++;
      $display("error at %0t: FIFOs not drained, fifo_empty %b", $time, fifo_empty);
    end
  endtask

  task automatic check_buffer();
    int        cycles;
    int        n;
    buf_addr_t addr;
    cycles = 0;
    n      = exp_y.size();
    while (!tile_done && cycles < TILE_LIMIT) begin
      @(posedge clk);
      cycles++;
    end
    if (!tile_done) begin
      main_errs++;
      $display("tile_done never rose after the last tile");
    end
    assert (words_written == idx_t'(n)) else begin
      main_errs++;
      $display("error at %0t: words_written %0d, expected %0d", $time, words_written, n);
    end
    // new address every cycle, data one cycle behind it
    for (int i = 0; i < n + 2; i++) begin
      @(posedge clk);
      if (i < n) begin
        addr = buf_addr_t'((int'(exp_y[i]) * `BUF_F_STRIDE + int'(exp_f[i])) % `BUF_DEPTH);
        buf_rd_addr <= addr;
      end
      if (i >= 2) begin
        assert (buf_rd_data == exp_data[i - 2]) else begin
          main_errs++;
          $display("error at %0t: buffer read %0d got %h, expected %h", $time, i - 2,
                   buf_rd_data, exp_data[i - 2]);
        end
      end
    end
  endtask

  task automatic report_test(input string name, input int errs_before);
    if (total_errs() == errs_before) begin
      tests_passed++;
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: %0d errors", name, total_errs() - errs_before);
    end
  endtask

  ////////////////////////////////////////
  // output monitor
  ////////////////////////////////////////
  always @(posedge clk) begin
    if (reset) begin
      run_q     = 1'b0;
      ddr_q     = 1'b0;
      start_q   = 1'b0;
      steps     = 0;
      mon_count = 0;
    end else begin
      // a valid output exactly one cycle after each step
      step_prev = run_q && ddr_q;
      assert (valid_out == step_prev) else begin
        mon_errs++;
        $display("error at %0t: valid_out %0b, step in previous cycle %0b", $time,
                 valid_out, step_prev);
      end
      if (start_q) begin
        steps     = 0;
        mon_count = 0;
      end else if (step_prev) begin
        steps++;
      end
      run_q   = start_q || (run_q && !(step_prev && steps == exp_y.size()));
      ddr_q   = ddr_en;
      start_q = conv_fifo_out_start;
      if (valid_out) begin
        if (mon_count < exp_y.size()) begin
          assert (out_y_idx == exp_y[mon_count] && out_x_idx == exp_x[mon_count] &&
                  out_f_idx == exp_f[mon_count] && conv_out_data == exp_data[mon_count])
          else begin
            mon_errs++;
            $display("error at %0t: output %0d got y%0d x%0d f%0d %h, expected y%0d x%0d f%0d %h",
                     $time, mon_count, out_y_idx, out_x_idx, out_f_idx, conv_out_data,
                     exp_y[mon_count], exp_x[mon_count], exp_f[mon_count],
                     exp_data[mon_count]);
          end
          // FIFO index is column times row count plus row
          assert (int'(fifo_row_no) == exp_fifo[mon_count] % `SA_ROW_NUM &&
                  int'(fifo_column_no) == exp_fifo[mon_count] / `SA_ROW_NUM)
          else begin
            mon_errs++;
            $display("error at %0t: output %0d row %0d col %0d, expected FIFO %0d",
                     $time, mon_count, fifo_row_no, fifo_column_no, exp_fifo[mon_count]);
          end
        end else begin
          mon_errs++;
          $display("valid output beyond the %0d predicted ones", exp_y.size());
        end
        mon_count++;
      end else begin
        assert (conv_out_data == '0) else begin
          mon_errs++;
          $display("error at %0t: conv_out_data %h while not valid", $time, conv_out_data);
        end
      end
      if (conv_fifo_out_tile_add_end) begin
        assert (mon_count == exp_y.size()) else begin
          mon_errs++;
          $display("error at %0t: tile end after %0d outputs", $time, mon_count);
        end
      end
    end
  end

  // tile end lands on the last valid output
  assert property (@(posedge clk) disable iff (reset)
    conv_fifo_out_tile_add_end |-> valid_out)
  else begin
    end_errs++;
    $display("error at %0t: tile end pulse without a valid output", $time);
  end

  assert property (@(posedge clk) disable iff (reset)
    conv_fifo_out_tile_add_end |=> (out_y_idx == '0 && out_x_idx == '0 && out_f_idx == '0))
  else begin
    clear_errs++;
    $display("error at %0t: index outputs not cleared after tile end", $time);
  end

  // tile_done rises one cycle after the end pulse
  assert property (@(posedge clk) disable iff (reset)
    conv_fifo_out_tile_add_end |=> tile_done)
  else begin
    end_errs++;
    $display("error at %0t: tile_done low after the tile end pulse", $time);
  end

  assert property (@(posedge clk) disable iff (reset)
    $rose(tile_done) |-> $past(conv_fifo_out_tile_add_end))
  else begin
    end_errs++;
    $display("error at %0t: tile_done rose without a tile end pulse", $time);
  end

  assert property (@(posedge clk) disable iff (reset)
    conv_fifo_out_start |=> !tile_done)
  else begin
    end_errs++;
    $display("error at %0t: tile_done not cleared by start", $time);
  end

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired before the tests finished");
    $display("Simulation FAILED");
    $finish;
  end

  initial begin
    int errs;
    reset               <= 1'b1;
    pe_wr_en            <= '0;
    pe_wr_data          <= '0;
    conv_fifo_out_start <= 1'b0;
    ddr_en              <= 1'b1;
    mode                <= 1'b0;
    cur_ox_start        <= '0;
    cur_oy_start        <= '0;
    cur_of_start        <= '0;
    cur_poy             <= '0;
    cur_pof             <= '0;
    buf_rd_addr         <= '0;
    lfsr_state = 32'h867f;
    repeat (RESET_CYCLES) @(posedge clk);
    reset <= 1'b0;
    @(posedge clk);

    errs = total_errs();
    assert (!valid_out && !conv_fifo_out_tile_add_end && !tile_done && words_written == '0)
    else begin
      main_errs++;
      $display("error at %0t: outputs not cleared by reset", $time);
    end
    report_test("reset_state", errs);

    errs = total_errs();
    run_tile(1'b0, 3, 20, 1'b0, 1'b0);
    report_test("mode0_tile", errs);

    // same words again, ddr_en now gapped
    errs = total_errs();
    run_tile(1'b0, 3, 20, 1'b1, 1'b1);
    report_test("ddr_gaps", errs);

    errs = total_errs();
    run_tile(1'b1, 2, 40, 1'b0, 1'b0);
    report_test("mode1_tile", errs);

    errs = total_errs();
    check_buffer();
    report_test("buffer_contents", errs);

    $display("tests passed %0d, failed %0d, check errors %0d", tests_passed, tests_failed,
             total_errs());
    if (tests_failed == 0 && total_errs() == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- src.f
+incdir+.
conv_out_pkg.sv
conv_row_fifo.sv
conv_fifo_bank.sv
conv_fifo_out_controller.sv
conv_out_buffer.sv
conv_out_top.sv
tb_conv_out.sv

//--- run_sim.sh
#!/bin/sh
# build the testbench with Verilator, run it, and look for the pass line
cd "$(dirname "$0")" && \
  verilator --binary --timing --assert -f src.f --top-module tb_conv_out -o sim_conv_out \
  || exit 1
out=$(./obj_dir/sim_conv_out)
echo "$out"
echo "$out" | grep -qx "Simulation PASSED" && exit 0 || exit 1
